//--- adc_pkg.sv
package adc_pkg;

  // one adc conversion result
  localparam int SAMPLE_W = 24;

  // samples carried per capture word
  localparam int NUM_LANES = 4;

  // full capture word on the write side
  localparam int WORD_W = SAMPLE_W * NUM_LANES;

  // lane counter width in the serializer
  localparam int LANE_IDX_W = $clog2(NUM_LANES);

  // lane 0 holds bits [SAMPLE_W-1:0] of the word
  // higher lanes follow toward the msb

endpackage

//--- fifo_pkg.sv
package fifo_pkg;

  import adc_pkg::*;

  // entries in the crossing buffer
  localparam int FIFO_DEPTH = 16;

  // address bits plus one wrap bit
  localparam int PTR_W = $clog2(FIFO_DEPTH) + 1;

  // sync tag in the msb, sample below it
  localparam int ENTRY_W = SAMPLE_W + 1;

endpackage

//--- adc_stream_mux.sv
`timescale 1ns/1ns

module adc_stream_mux
  import adc_pkg::*;
(
  input  logic                wr_clk,
  input  logic                rst,
  input  logic [WORD_W-1:0]   din,
  input  logic                dvld,
  output logic [SAMPLE_W-1:0] wr_sample,
  output logic                wr_sync,
  output logic                wr_en
);

  // held capture word and lane stepping
  logic [WORD_W-1:0]     word_q;
  logic [LANE_IDX_W-1:0] lane;
  logic                  busy;
  logic                  last_lane;
  logic                  accept;

  // first register stage after lane select
  logic [SAMPLE_W-1:0]   s1_sample;
  logic                  s1_sync;
  logic                  s1_vld;

  assign last_lane = (lane == LANE_IDX_W'(NUM_LANES - 1));

  // new word taken when idle or on the final lane
  // so back-to-back words four cycles apart still fit
  assign accept = dvld && (!busy || last_lane);

  always_ff @(posedge wr_clk) begin
    if (rst) begin
      busy    <= 1'b0;
      lane    <= '0;
      s1_sync <= 1'b0;
      s1_vld  <= 1'b0;
      wr_sync <= 1'b0;
      wr_en   <= 1'b0;
    end else begin
      // one lane out per cycle while busy
      s1_vld  <= busy;
      s1_sync <= busy && (lane == '0);
      if (busy) begin
        lane <= lane + 1'b1;
      end
      if (accept) begin
        busy <= 1'b1;
        lane <= '0;
      end else if (busy && last_lane) begin
        busy <= 1'b0;
      end
      // fifo side pipeline stage
      wr_sync <= s1_sync;
      wr_en   <= s1_vld;
    end
  end

  // payload path
  always_ff @(posedge wr_clk) begin
    if (accept) begin
      word_q <= din;
    end
    // low lanes first
    s1_sample <= word_q[lane*SAMPLE_W +: SAMPLE_W];
    wr_sample <= s1_sample;
  end

endmodule

//--- adc_async_fifo.sv
`timescale 1ns/1ns

module adc_async_fifo
  import fifo_pkg::*;
(
  input  logic               wr_clk,
  input  logic               rd_clk,
  input  logic               rst,
  input  logic [ENTRY_W-1:0] wr_data,
  input  logic               wr_en,
  input  logic               rd_en,
  output logic [ENTRY_W-1:0] rd_data,
  output logic               full,
  output logic               empty,
  output logic               overflow,
  output logic               underflow
);

  // storage
  logic [ENTRY_W-1:0] mem [FIFO_DEPTH];

  // write domain pointers
  logic [PTR_W-1:0] wr_bin;
  logic [PTR_W-1:0] wr_bin_nxt;
  logic [PTR_W-1:0] wr_gray;
  logic             wr_push;

  // read domain pointers
  logic [PTR_W-1:0] rd_bin;
  logic [PTR_W-1:0] rd_bin_nxt;
  logic [PTR_W-1:0] rd_gray;
  logic             rd_pop;

  // gray pointers after two flops in the far domain
  logic [PTR_W-1:0] rd_gray_w1;
  logic [PTR_W-1:0] rd_gray_w2;
  logic [PTR_W-1:0] wr_gray_r1;
  logic [PTR_W-1:0] wr_gray_r2;

  function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] b);
    return b ^ (b >> 1);
  endfunction

  // write side
  assign wr_push    = wr_en && !full;
  assign wr_bin_nxt = wr_bin + PTR_W'(wr_push);

  // full when gray pointers differ only in the top two bits
  assign full = (wr_gray == {~rd_gray_w2[PTR_W-1 -: 2], rd_gray_w2[PTR_W-3:0]});

  always_ff @(posedge wr_clk) begin
    if (rst) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
      overflow   <= 1'b0;
    end else begin
      wr_bin     <= wr_bin_nxt;
      wr_gray    <= bin2gray(wr_bin_nxt);
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
      // refused write, entry dropped
      overflow   <= wr_en && full;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_push) begin
      mem[wr_bin[PTR_W-2:0]] <= wr_data;
    end
  end

  // read side
  assign rd_pop     = rd_en && !empty;
  assign rd_bin_nxt = rd_bin + PTR_W'(rd_pop);

  // empty on exact gray match
  assign empty = (rd_gray == wr_gray_r2);

  always_ff @(posedge rd_clk) begin
    if (rst) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
      underflow  <= 1'b0;
    end else begin
      rd_bin     <= rd_bin_nxt;
      rd_gray    <= bin2gray(rd_bin_nxt);
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
      // refused read, pointers hold
      underflow  <= rd_en && empty;
    end
  end

  // registered output, one cycle after the accepted read
  always_ff @(posedge rd_clk) begin
    if (rd_pop) begin
      rd_data <= mem[rd_bin[PTR_W-2:0]];
    end
  end

endmodule

//--- adc_read_port.sv
`timescale 1ns/1ns

module adc_read_port
  import adc_pkg::*;
  import fifo_pkg::*;
(
  input  logic                rd_clk,
  input  logic                rst,
  input  logic                rd_en,
  input  logic [ENTRY_W-1:0]  fifo_rdata,
  input  logic                fifo_empty_raw,
  input  logic                fifo_uf_raw,
  output logic                fifo_rd_en,
  output logic [SAMPLE_W-1:0] dout,
  output logic                dout_sync,
  output logic                dout_vld,
  output logic                fifo_empty,
  output logic                fifo_uf
);

  // read accepted by the fifo on this cycle
  logic rd_accept;

  assign rd_accept = fifo_rd_en && !fifo_empty_raw;

  always_ff @(posedge rd_clk) begin
    if (rst) begin
      fifo_rd_en <= 1'b0;
      fifo_empty <= 1'b1;
      dout_vld   <= 1'b0;
    end else begin
      // consumer strobe retimed toward the fifo
      fifo_rd_en <= rd_en;
      fifo_empty <= fifo_empty_raw;
      // data lands together with this flag
      dout_vld   <= rd_accept;
    end
  end

  // split the entry
  assign dout = fifo_rdata[SAMPLE_W-1:0];

  // tag only shown with valid data
  assign dout_sync = fifo_rdata[ENTRY_W-1] & dout_vld;

  // already a registered pulse
  assign fifo_uf = fifo_uf_raw;

endmodule

//--- adc_retime.sv
`timescale 1ns/1ns

module adc_retime
  import adc_pkg::*;
  import fifo_pkg::*;
(
  input  logic                wr_clk,
  input  logic                rd_clk,
  input  logic                rst,
  input  logic [WORD_W-1:0]   din,
  input  logic                dvld,
  input  logic                rd_en,
  output logic [SAMPLE_W-1:0] dout,
  output logic                dout_sync,
  output logic                dout_vld,
  output logic                fifo_of,
  output logic                fifo_uf,
  output logic                fifo_empty
);

  // serializer to fifo
  logic [SAMPLE_W-1:0] wr_sample;
  logic                wr_sync;
  logic                wr_en;

  // fifo to read port
  logic                fifo_rd_en;
  logic [ENTRY_W-1:0]  fifo_dout;
  logic                fifo_empty_raw;
  logic                fifo_uf_raw;

  adc_stream_mux adc_stream_mux_inst (
    .wr_clk    (wr_clk),
    .rst       (rst),
    .din       (din),
    .dvld      (dvld),
    .wr_sample (wr_sample),
    .wr_sync   (wr_sync),
    .wr_en     (wr_en)
  );

  // entry is sync tag over sample
  // full stays inside, no back-pressure toward the adc
  adc_async_fifo adc_async_fifo_inst (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .rst       (rst),
    .wr_data   ({wr_sync, wr_sample}),
    .wr_en     (wr_en),
    .rd_en     (fifo_rd_en),
    .rd_data   (fifo_dout),
    .full      (),
    .empty     (fifo_empty_raw),
    .overflow  (fifo_of),
    .underflow (fifo_uf_raw)
  );

  adc_read_port adc_read_port_inst (
    .rd_clk         (rd_clk),
    .rst            (rst),
    .rd_en          (rd_en),
    .fifo_rdata     (fifo_dout),
    .fifo_empty_raw (fifo_empty_raw),
    .fifo_uf_raw    (fifo_uf_raw),
    .fifo_rd_en     (fifo_rd_en),
    .dout           (dout),
    .dout_sync      (dout_sync),
    .dout_vld       (dout_vld),
    .fifo_empty     (fifo_empty),
    .fifo_uf        (fifo_uf)
  );

endmodule

//--- adc_retime_sva.sv
`timescale 1ns/1ns

module adc_retime_sva
  import fifo_pkg::*;
(
  input logic               wr_clk,
  input logic               rd_clk,
  input logic               rst,
  input logic [ENTRY_W-1:0] wr_data,
  input logic               wr_en,
  input logic               rd_en,
  input logic               full,
  input logic               empty,
  input logic               overflow,
  input logic               underflow
);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // flags from two domains seen on wr_clk
  full_and_empty: assert property (@(posedge wr_clk) disable iff (rst) !(full && empty))
    else begin
      fail_cnt++;
      $error("full and empty set together");
    end

  // overflow only after a refused write
  overflow_cause: assert property (
    @(posedge wr_clk) disable iff (rst) overflow |-> $past(wr_en && full))
    else begin
      fail_cnt++;
      $error("overflow without a write while full");
    end

  // underflow only after a refused read
  underflow_cause: assert property (
    @(posedge rd_clk) disable iff (rst) underflow |-> $past(rd_en && empty))
    else begin
      fail_cnt++;
      $error("underflow without a read while empty");
    end

  // reset values in each domain
  wr_reset_flags: assert property (@(posedge wr_clk) rst |=> (!overflow && !full))
    else begin
      fail_cnt++;
      $error("wr_clk flags not cleared by reset");
    end

  rd_reset_flags: assert property (@(posedge rd_clk) rst |=> (!underflow && empty))
    else begin
      fail_cnt++;
      $error("rd_clk flags not cleared by reset");
    end

  // no unknown data pushed
  wr_data_known: assert property (
    @(posedge wr_clk) disable iff (rst) wr_en |-> !$isunknown(wr_data))
    else begin
      fail_cnt++;
      $error("unknown entry written");
    end

endmodule

bind adc_async_fifo adc_retime_sva adc_retime_sva_inst (.*);

//--- tb_adc_retime.sv
`timescale 1ns/1ns

module tb_adc_retime
  import adc_pkg::*;
();

  // wr_clk 6 ns and rd_clk 4 ns
  localparam int WR_HALF = 3;
  localparam int RD_HALF = 2;
  localparam logic [31:0] SEED = 32'hb1b98525;
  // wait limits in rd_clk cycles
  localparam int EMPTY_WAIT = 40;
  localparam int VLD_WAIT = 8;
  localparam int RUN_WAIT = 6000;
  localparam int RAND_WORDS = 40;

  logic                wr_clk = 1'b0;
  logic                rd_clk = 1'b0;
  logic                rst;
  logic [WORD_W-1:0]   din;
  logic                dvld;
  logic                rd_en;
  logic [SAMPLE_W-1:0] dout;
  logic                dout_sync;
  logic                dout_vld;
  logic                fifo_of;
  logic                fifo_uf;
  logic                fifo_empty;

  // expected {sync, sample} in read order
  logic [SAMPLE_W:0] exp_q[$];
  logic [31:0]       lfsr_state = SEED;
  int                err_cnt = 0;
  int                timeout_cnt = 0;
  int                of_cnt = 0;

  always #WR_HALF wr_clk = ~wr_clk;
  always #RD_HALF rd_clk = ~rd_clk;

  adc_retime adc_retime_inst (.*);

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [WORD_W-1:0] rand_word();
    logic [WORD_W-1:0] w;
    for (int i = 0; i < WORD_W; i++)
      w[i] = take_bit();
    return w;
  endfunction

  // lane k sits at bits [k*SAMPLE_W +: SAMPLE_W]
  // only lane 0 carries the tag
  function automatic logic [SAMPLE_W:0] ref_entry(input logic [WORD_W-1:0] w, input int lane);
    logic [SAMPLE_W-1:0] sample;
    sample = SAMPLE_W'(w >> (lane * SAMPLE_W));
    return {lane == 0, sample};
  endfunction

  function automatic void flag_error(input string msg);
    err_cnt++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endfunction

  function automatic void note_timeout(input string what);
    timeout_cnt++;
    $display("timeout at %0t ns while waiting for %s", $time, what);
  endfunction

  // count overflow pulses mid cycle
  always @(negedge wr_clk) begin
    if (fifo_of === 1'b1)
      of_cnt++;
  end

  // one expected entry per valid beat
  always @(negedge rd_clk) begin
    logic [SAMPLE_W:0] want;
    if (dout_vld === 1'b1) begin
      if (exp_q.size() == 0) begin
        flag_error("dout_vld with no expected sample");
      end else begin
        want = exp_q.pop_front();
        if (dout !== want[SAMPLE_W-1:0] || dout_sync !== want[SAMPLE_W])
          flag_error($sformatf("got sync %b sample %h, expected sync %b sample %h",
                               dout_sync, dout, want[SAMPLE_W], want[SAMPLE_W-1:0]));
      end
    end else if (dout_sync === 1'b1) begin
      flag_error("dout_sync high without dout_vld");
    end
  end

  // one word and its four entries when kept
  // then idle spacing
  task automatic send_word(input logic [WORD_W-1:0] w, input bit keep, input int gap);
    @(negedge wr_clk);
    din  = w;
    dvld = 1'b1;
    for (int k = 0; k < NUM_LANES; k++) begin
      if (keep)
        exp_q.push_back(ref_entry(w, k));
    end
    @(negedge wr_clk);
    dvld = 1'b0;
    repeat (gap - 1) @(negedge wr_clk);
  endtask

  // single read once data is there
  // latency counted in rd_clk cycles
  task automatic read_one();
    int n;
    @(negedge rd_clk);
    n = 0;
    while (fifo_empty !== 1'b0 && n < EMPTY_WAIT) begin
      @(negedge rd_clk);
      n++;
    end
    if (fifo_empty !== 1'b0) begin
      note_timeout("fifo_empty to fall");
      return;
    end
    rd_en = 1'b1;
    @(negedge rd_clk);
    rd_en = 1'b0;
    n = 1;
    while (dout_vld !== 1'b1 && n < VLD_WAIT) begin
      @(negedge rd_clk);
      n++;
    end
    if (dout_vld !== 1'b1)
      note_timeout("dout_vld after a read");
    else if (n != 2)
      flag_error($sformatf("dout_vld %0d cycles after rd_en, expected 2", n));
    // registered empty flag catches up
    @(negedge rd_clk);
  endtask

  initial begin
    int n;
    int reads;
    int got;
    int of_base;
    int assert_fails;
    bit saw_uf;
    bit saw_vld;
    logic [WORD_W-1:0] words[RAND_WORDS];
    int gaps[RAND_WORDS];

    rst   = 1'b1;
    din   = '0;
    dvld  = 1'b0;
    rd_en = 1'b0;
    repeat (5) @(posedge rd_clk);
    @(negedge rd_clk);
    rst = 1'b0;
    // quiet after reset
    repeat (6) begin
      @(negedge rd_clk);
      if (fifo_empty !== 1'b1 || dout_vld !== 1'b0 || fifo_uf === 1'b1)
        flag_error("fifo_empty, dout_vld or fifo_uf wrong after reset");
    end
    if (of_cnt != 0)
      flag_error("fifo_of pulse before the first stimulus");

    // single words read back lane by lane
    repeat (3) begin
      send_word(rand_word(), 1'b1, 5);
      repeat (NUM_LANES) read_one();
    end

    // five words into 16 entries
    // last word is dropped
    of_base = of_cnt;
    for (int i = 0; i < 5; i++)
      send_word(rand_word(), i < 4, 5);
    repeat (10) @(negedge wr_clk);
    @(negedge rd_clk);
    if (of_cnt == of_base)
      flag_error("no fifo_of pulse after 20 samples without reads");
    reads = 0;
    while (fifo_empty === 1'b0 && reads < 24) begin
      read_one();
      reads++;
    end
    if (reads != 16 || exp_q.size() != 0 || fifo_empty !== 1'b1)
      flag_error($sformatf("drain gave %0d entries, %0d expected left, fifo_empty %b",
                           reads, exp_q.size(), fifo_empty));

    // read on the empty fifo
    @(negedge rd_clk);
    rd_en = 1'b1;
    @(negedge rd_clk);
    rd_en   = 1'b0;
    saw_uf  = 1'b0;
    saw_vld = 1'b0;
    repeat (VLD_WAIT) begin
      @(negedge rd_clk);
      saw_uf  = saw_uf | (fifo_uf === 1'b1);
      saw_vld = saw_vld | (dout_vld === 1'b1);
    end
    if (!saw_uf || saw_vld)
      flag_error("read on empty fifo gave no fifo_uf pulse or a dout_vld");

    // paced traffic with writer draws made up front
    for (int i = 0; i < RAND_WORDS; i++) begin
      words[i] = rand_word();
      gaps[i]  = 5;
      if (take_bit())
        gaps[i] += 2;
      if (take_bit())
        gaps[i] += 1;
    end
    of_base = of_cnt;
    got     = 0;
    n       = 0;
    fork
      begin
        for (int i = 0; i < RAND_WORDS; i++)
          send_word(words[i], 1'b1, gaps[i]);
      end
      begin
        // reads on about three cycles in four
        while (got < RAND_WORDS * NUM_LANES && n < RUN_WAIT) begin
          @(negedge rd_clk);
          if (dout_vld === 1'b1)
            got++;
          rd_en = take_bit() | take_bit();
          n++;
        end
        rd_en = 1'b0;
      end
    join
    if (got < RAND_WORDS * NUM_LANES)
      note_timeout("all paced samples to come back");
    repeat (4) @(negedge rd_clk);
    if (exp_q.size() != 0 || of_cnt != of_base)
      flag_error($sformatf("%0d samples missing, %0d fifo_of pulses in paced traffic",
                           exp_q.size(), of_cnt - of_base));

    assert_fails = adc_retime_inst.adc_async_fifo_inst.adc_retime_sva_inst.fail_cnt;
    $display("errors %0d, timeouts %0d, assertion failures %0d",
             err_cnt, timeout_cnt, assert_fails);
    if (err_cnt == 0 && timeout_cnt == 0 && assert_fails == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- filelist.f
adc_pkg.sv
fifo_pkg.sv
adc_stream_mux.sv
adc_async_fifo.sv
adc_read_port.sv
adc_retime.sv
adc_retime_sva.sv
tb_adc_retime.sv

//--- Bender.yml
package:
  name: adc_retime

sources:
  - adc_pkg.sv
  - fifo_pkg.sv
  - adc_stream_mux.sv
  - adc_async_fifo.sv
  - adc_read_port.sv
  - adc_retime.sv
  - target: test
    files:
      - adc_retime_sva.sv
      - tb_adc_retime.sv
